// ==== build.f ====
hw/tama_pkg.sv
hw/bridge_settings.sv
hw/button_handler.sv
hw/clock_enable_gen.sv
hw/buzzer_monitor.sv
hw/rom_store.sv
hw/tama_shell.sv
testbench/tb_tama_shell.sv

// ==== hw/bridge_settings.sv ====
// Bridge register block for the shell settings.
// Writes land in the setting bits, the CPU reset-hold counter or the
// turbo speed strobe; reads are a combinational mux on the address.

module bridge_settings #(
  parameter int unsigned reset_hold_cycles = 32'h0010_0000
) (
  input  logic                     clk_sys_117_964,
  input  logic                     ss_begin_reset,
  input  tama_pkg::bridge_addr_t   bridge_addr,
  input  logic                     bridge_wr,
  input  tama_pkg::bridge_word_t   bridge_wr_data,
  input  tama_pkg::speed_t         turbo_speed,
  output tama_pkg::bridge_word_t   bridge_rd_data,
  output tama_pkg::core_settings_t settings,
  output logic                     speed_wr,
  output tama_pkg::speed_t         speed_wr_value,
  output logic                     cpu_reset
);

  import tama_pkg::*;

  localparam int unsigned hold_w = $clog2(reset_hold_cycles + 1);

  logic [hold_w-1:0] hold_count;
  speed_t            wr_speed_raw;

  ////////////////////////////////////////////////////////////
  // write decode

  always_ff @(posedge clk_sys_117_964) begin
    if (ss_begin_reset) begin
      settings   <= '0;
      hold_count <= '0;
    end else begin
      if (hold_count != 0) begin
        hold_count <= hold_count - 1'b1;
      end

      if (bridge_wr) begin
        case (bridge_addr)
          addr_reset_cpu:      hold_count <= hold_w'(reset_hold_cycles);
          addr_disable_sound:  settings.disable_sound <= bridge_wr_data[0];
          addr_cancel_turbo:   settings.cancel_turbo_on_event <= bridge_wr_data[0];
          addr_suppress_turbo: settings.suppress_turbo_after_activation <= bridge_wr_data[0];
          default: ;
        endcase
      end
    end
  end

  // speed itself lives in the button handler, pass a strobe across
  assign wr_speed_raw   = bridge_wr_data[2:0];
  assign speed_wr       = bridge_wr && (bridge_addr == addr_turbo_speed);
  assign speed_wr_value = (wr_speed_raw > speed_max) ? speed_max : wr_speed_raw;

  // CPU held in reset while the counter runs
  assign cpu_reset = ss_begin_reset || (hold_count != 0);

  ////////////////////////////////////////////////////////////
  // read mux

  always_comb begin
    case (bridge_addr)
      addr_turbo_speed: bridge_rd_data = {29'b0, turbo_speed};
      default:          bridge_rd_data = '0;
    endcase
  end

  // release of the CPU reset only ever comes from the counter expiring
  a_reset_release: assert property (
    @(posedge clk_sys_117_964) disable iff (ss_begin_reset)
    ($fell(cpu_reset) && !$past(ss_begin_reset)) |-> ($past(hold_count) == 1)
  ) else $error("cpu_reset released before hold counter expired");

endmodule

// ==== hw/button_handler.sv ====
// Turbo speed owner and controller key handling.
// Shoulder buttons step the speed with a repeat delay, bridge writes and
// the turbo cancel pulse override it, and face keys map to CPU inputs.

module button_handler #(
  parameter int unsigned button_repeat_cycles = 2**25,
  parameter int unsigned ui_hold_cycles       = 2**27
) (
  input  logic             clk_sys_117_964,
  input  logic             ss_begin_reset,
  input  tama_pkg::key_t   cont1_key,
  input  logic             speed_wr,
  input  tama_pkg::speed_t speed_wr_value,
  input  logic             turbo_cancel,
  output tama_pkg::speed_t turbo_speed,
  output logic             turbo_ui_active,
  output logic [3:0]       cpu_input_k0
);

  import tama_pkg::*;

  localparam int unsigned repeat_w = $clog2(button_repeat_cycles + 1);
  localparam int unsigned ui_w     = $clog2(ui_hold_cycles + 1);

  logic [repeat_w-1:0] repeat_count;
  logic [ui_w-1:0]     ui_count;
  logic                trig_l1;
  logic                trig_r1;
  logic                used_button;
  speed_t              speed_next;

  assign trig_l1 = cont1_key[key_trig_l1];
  assign trig_r1 = cont1_key[key_trig_r1];

  ////////////////////////////////////////////////////////////
  // next speed

  always_comb begin
    speed_next  = turbo_speed;
    used_button = 1'b0;

    // in-game event, drop back to 1x and show it
    if (turbo_cancel && turbo_speed != 0) begin
      used_button = 1'b1;
      speed_next  = '0;
    end

    if (repeat_count == 0) begin
      if (trig_l1) begin
        used_button = 1'b1;
        if (turbo_speed != 0) begin
          speed_next = turbo_speed - 3'd1;
        end
      end else if (trig_r1) begin
        used_button = 1'b1;
        if (turbo_speed < speed_max) begin
          speed_next = turbo_speed + 3'd1;
        end
      end
    end

    // host write has the last word
    if (speed_wr) begin
      speed_next = speed_wr_value;
    end
  end

  ////////////////////////////////////////////////////////////
  // registers

  always_ff @(posedge clk_sys_117_964) begin
    if (ss_begin_reset) begin
      turbo_speed     <= '0;
      repeat_count    <= '0;
      ui_count        <= '0;
      turbo_ui_active <= 1'b0;
    end else begin
      turbo_speed <= speed_next;

      // letting go of both triggers allows an immediate step
      if (!trig_l1 && !trig_r1) begin
        repeat_count <= '0;
      end else if (used_button) begin
        repeat_count <= repeat_w'(button_repeat_cycles);
      end else if (repeat_count != 0) begin
        repeat_count <= repeat_count - 1'b1;
      end

      if (used_button) begin
        ui_count        <= ui_w'(ui_hold_cycles);
        turbo_ui_active <= 1'b1;
      end else if (ui_count != 0) begin
        ui_count <= ui_count - 1'b1;
      end else begin
        turbo_ui_active <= 1'b0;
      end
    end
  end

  // left, middle, right keys, active low
  assign cpu_input_k0 = {1'b0, ~cont1_key[key_face_y], ~cont1_key[key_face_b],
                         ~cont1_key[key_face_a]};

  a_speed_range: assert property (
    @(posedge clk_sys_117_964) disable iff (ss_begin_reset)
    turbo_speed <= speed_max
  ) else $error("turbo_speed above full speed");

endmodule

// ==== hw/buzzer_monitor.sv ====
// Buzzer monitor.
// Cancels turbo when the game sounds the buzzer, except during a suppress
// window right after turbo is turned on, and gates the audio sample.

module buzzer_monitor #(
  parameter int unsigned suppress_ticks = 32'h0002_8000
) (
  input  logic                     clk_sys_117_964,
  input  logic                     ss_begin_reset,
  input  tama_pkg::core_settings_t settings,
  input  tama_pkg::speed_t         turbo_speed,
  input  logic                     buzzer,
  input  logic                     clk_en,
  output logic                     turbo_cancel,
  output tama_pkg::audio_sample_t  audio_sample
);

  import tama_pkg::*;

  localparam int unsigned suppress_w = $clog2(suppress_ticks + 1);

  logic [suppress_w-1:0] suppress_count;
  logic [suppress_w-1:0] suppress_next;
  logic                  prev_speed_zero;
  logic                  cancel_now;

  ////////////////////////////////////////////////////////////
  // suppress window, counted in CPU time

  always_comb begin
    suppress_next = suppress_count;

    // turbo just switched on
    if (turbo_speed != 0 && prev_speed_zero &&
        settings.suppress_turbo_after_activation) begin
      suppress_next = suppress_w'(suppress_ticks);
    end

    cancel_now = settings.cancel_turbo_on_event && buzzer && (suppress_next == 0);

    if (clk_en && suppress_count != 0) begin
      suppress_next = suppress_next - 1'b1;
    end
  end

  always_ff @(posedge clk_sys_117_964) begin
    if (ss_begin_reset) begin
      prev_speed_zero <= 1'b1;
      suppress_count  <= '0;
      turbo_cancel    <= 1'b0;
    end else begin
      prev_speed_zero <= (turbo_speed == 0);
      suppress_count  <= suppress_next;
      turbo_cancel    <= cancel_now;
    end
  end

  // no sound above 2x
  assign audio_sample = (!settings.disable_sound && turbo_speed < 3'd2) ?
                        {2'b0, {13{buzzer}}} : '0;

endmodule

// ==== hw/clock_enable_gen.sv ====
// CPU clock enable generator.
// A down-counter on the system clock produces the 1x enable at the end of
// each period and a 2x enable at the period's half point.

module clock_enable_gen #(
  parameter int unsigned base_div_count = 3600
) (
  input  logic             clk_sys_117_964,
  input  logic             ss_begin_reset,
  input  tama_pkg::speed_t turbo_speed,
  output logic             clk_en,
  output logic             clk_2x_en
);

  import tama_pkg::*;

  localparam div_count_t base_count = div_count_t'(base_div_count);

  div_count_t reload;
  div_count_t div_count;
  div_count_t half_point;

  ////////////////////////////////////////////////////////////
  // speed table

  always_comb begin
    case (turbo_speed)
      3'd0:    reload = base_count;
      3'd1:    reload = base_count / 12'd2;
      3'd2:    reload = base_count / 12'd4;
      3'd3:    reload = base_count / 12'd50;
      // full speed
      default: reload = 12'd1;
    endcase
  end

  ////////////////////////////////////////////////////////////
  // divider

  always_ff @(posedge clk_sys_117_964) begin
    if (ss_begin_reset) begin
      div_count  <= base_count;
      half_point <= base_count / 12'd2;
      clk_en     <= 1'b0;
      clk_2x_en  <= 1'b0;
    end else begin
      clk_en    <= 1'b0;
      clk_2x_en <= 1'b0;

      if (div_count == 0) begin
        div_count <= reload;
        // half point taken with the reload so a speed change
        // mid-period cannot skip or double a 2x tick
        half_point <= (reload == 12'd1) ? 12'd1 : reload / 12'd2;
        clk_en     <= 1'b1;
        clk_2x_en  <= 1'b1;
      end else begin
        div_count <= div_count - 12'd1;
        if (div_count == half_point) begin
          clk_2x_en <= 1'b1;
        end
      end
    end
  end

  // every 1x tick is also a 2x tick, and 1x never fires back to back
  a_enable_pair: assert property (
    @(posedge clk_sys_117_964) disable iff (ss_begin_reset)
    clk_en |-> clk_2x_en ##1 !clk_en
  ) else $error("clk_en without clk_2x_en or on consecutive cycles");

endmodule

// ==== hw/rom_store.sv ====
// Program ROM for the CPU core, 8K words of 16 bits.
// The loader writes byte-swapped words by byte address; the CPU reads
// the low 12 bits of a word one cycle after presenting its address.

module rom_store (
  input  logic                 clk_sys_117_964,
  input  logic                 rom_wr,
  input  tama_pkg::load_addr_t rom_wr_addr,
  input  tama_pkg::rom_word_t  rom_wr_data,
  input  tama_pkg::rom_addr_t  rom_addr,
  output tama_pkg::rom_data_t  rom_data
);

  import tama_pkg::*;

  rom_word_t rom_mem [8192];
  rom_word_t wr_word;

  // loader stream is big endian
  assign wr_word = {rom_wr_data[7:0], rom_wr_data[15:8]};

  ////////////////////////////////////////////////////////////
  // write port

  always_ff @(posedge clk_sys_117_964) begin
    if (rom_wr) begin
      // byte address to word address
      rom_mem[rom_wr_addr[13:1]] <= wr_word;
    end
  end

  ////////////////////////////////////////////////////////////
  // read port

  always_ff @(posedge clk_sys_117_964) begin
    rom_data <= rom_mem[rom_addr][11:0];
  end

endmodule

// ==== hw/tama_pkg.sv ====
// Shared types and constants for the virtual-pet CPU control shell.
// Imported by every RTL module of the shell.

package tama_pkg;

  ////////////////////////////////////////////////////////////
  // widths that carry a meaning

  typedef logic [31:0] bridge_addr_t;
  typedef logic [31:0] bridge_word_t;
  typedef logic [15:0] key_t;
  typedef logic [2:0]  speed_t;
  typedef logic [11:0] div_count_t;
  typedef logic [12:0] rom_addr_t;
  typedef logic [20:0] load_addr_t;
  typedef logic [15:0] rom_word_t;
  typedef logic [11:0] rom_data_t;
  typedef logic [14:0] audio_sample_t;

  // turbo index 4 means run the CPU at full system speed
  localparam speed_t speed_max = 3'd4;

  // controller key bitmap positions
  localparam int key_face_a  = 4;
  localparam int key_face_b  = 5;
  localparam int key_face_y  = 7;
  localparam int key_trig_l1 = 8;
  localparam int key_trig_r1 = 9;

  ////////////////////////////////////////////////////////////
  // bridge address map

  localparam bridge_addr_t addr_reset_cpu      = 32'h0000_0000;
  localparam bridge_addr_t addr_disable_sound  = 32'h0000_0010;
  localparam bridge_addr_t addr_turbo_speed    = 32'h0000_0100;
  localparam bridge_addr_t addr_cancel_turbo   = 32'h0000_0104;
  localparam bridge_addr_t addr_suppress_turbo = 32'h0000_0108;

  // user settings written over the bridge
  typedef struct packed {
    logic disable_sound;
    logic cancel_turbo_on_event;
    logic suppress_turbo_after_activation;
  } core_settings_t;

endpackage

// ==== hw/tama_shell.sv ====
// Top level of the control shell around the virtual-pet CPU core.
// Connects settings, turbo control, clock enables, ROM and buzzer monitor;
// the CPU core itself sits outside and attaches to these ports.

module tama_shell #(
  parameter int unsigned button_repeat_cycles = 2**25,
  parameter int unsigned ui_hold_cycles       = 2**27,
  parameter int unsigned base_div_count       = 3600,
  parameter int unsigned suppress_ticks       = 32'h0002_8000,
  parameter int unsigned reset_hold_cycles    = 32'h0010_0000
) (
  input  logic                    clk_sys_117_964,
  input  logic                    ss_begin_reset,
  // bridge
  input  tama_pkg::bridge_addr_t  bridge_addr,
  input  logic                    bridge_wr,
  input  tama_pkg::bridge_word_t  bridge_wr_data,
  output tama_pkg::bridge_word_t  bridge_rd_data,
  // controller and CPU side
  input  tama_pkg::key_t          cont1_key,
  input  logic                    buzzer,
  output logic                    cpu_reset,
  output logic [3:0]              cpu_input_k0,
  output logic                    clk_en,
  output logic                    clk_2x_en,
  output logic                    turbo_ui_active,
  output tama_pkg::audio_sample_t audio_sample,
  // ROM load and fetch
  input  logic                    rom_wr,
  input  tama_pkg::load_addr_t    rom_wr_addr,
  input  tama_pkg::rom_word_t     rom_wr_data,
  input  tama_pkg::rom_addr_t     rom_addr,
  output tama_pkg::rom_data_t     rom_data
);

  import tama_pkg::*;

  core_settings_t settings;
  speed_t         turbo_speed;
  speed_t         speed_wr_value;
  logic           speed_wr;
  logic           turbo_cancel;

  bridge_settings #(
    .reset_hold_cycles (reset_hold_cycles)
  ) u_bridge_settings (
    .clk_sys_117_964 (clk_sys_117_964),
    .ss_begin_reset  (ss_begin_reset),
    .bridge_addr     (bridge_addr),
    .bridge_wr       (bridge_wr),
    .bridge_wr_data  (bridge_wr_data),
    .turbo_speed     (turbo_speed),
    .bridge_rd_data  (bridge_rd_data),
    .settings        (settings),
    .speed_wr        (speed_wr),
    .speed_wr_value  (speed_wr_value),
    .cpu_reset       (cpu_reset)
  );

  button_handler #(
    .button_repeat_cycles (button_repeat_cycles),
    .ui_hold_cycles       (ui_hold_cycles)
  ) u_button_handler (
    .clk_sys_117_964 (clk_sys_117_964),
    .ss_begin_reset  (ss_begin_reset),
    .cont1_key       (cont1_key),
    .speed_wr        (speed_wr),
    .speed_wr_value  (speed_wr_value),
    .turbo_cancel    (turbo_cancel),
    .turbo_speed     (turbo_speed),
    .turbo_ui_active (turbo_ui_active),
    .cpu_input_k0    (cpu_input_k0)
  );

  clock_enable_gen #(
    .base_div_count (base_div_count)
  ) u_clock_enable_gen (
    .clk_sys_117_964 (clk_sys_117_964),
    .ss_begin_reset  (ss_begin_reset),
    .turbo_speed     (turbo_speed),
    .clk_en          (clk_en),
    .clk_2x_en       (clk_2x_en)
  );

  buzzer_monitor #(
    .suppress_ticks (suppress_ticks)
  ) u_buzzer_monitor (
    .clk_sys_117_964 (clk_sys_117_964),
    .ss_begin_reset  (ss_begin_reset),
    .settings        (settings),
    .turbo_speed     (turbo_speed),
    .buzzer          (buzzer),
    .clk_en          (clk_en),
    .turbo_cancel    (turbo_cancel),
    .audio_sample    (audio_sample)
  );

  rom_store u_rom_store (
    .clk_sys_117_964 (clk_sys_117_964),
    .rom_wr          (rom_wr),
    .rom_wr_addr     (rom_wr_addr),
    .rom_wr_data     (rom_wr_data),
    .rom_addr        (rom_addr),
    .rom_data        (rom_data)
  );

endmodule

// ==== testbench/tb_tama_shell.sv ====
// Testbench for the virtual-pet control shell.
// Drives the bridge, keys, buzzer and ROM ports on the falling edge;
// immediate and concurrent assertions check every response.

module tb_tama_shell;

  timeunit 1ns;
  timeprecision 100ps;

  import tama_pkg::*;

  localparam int repeat_cycles = 20;
  localparam int ui_hold       = 40;
  localparam int base_div      = 100;
  localparam int suppress      = 3;
  localparam int reset_hold    = 16;
  localparam int wait_limit    = 1000;

  logic          clk_sys_117_964 = 1'b0;
  logic          ss_begin_reset;
  bridge_addr_t  bridge_addr;
  logic          bridge_wr;
  bridge_word_t  bridge_wr_data;
  bridge_word_t  bridge_rd_data;
  key_t          cont1_key;
  logic          buzzer;
  logic          cpu_reset;
  logic [3:0]    cpu_input_k0;
  logic          clk_en;
  logic          clk_2x_en;
  logic          turbo_ui_active;
  audio_sample_t audio_sample;
  logic          rom_wr;
  load_addr_t    rom_wr_addr;
  rom_word_t     rom_wr_data;
  rom_addr_t     rom_addr;
  rom_data_t     rom_data;

  integer    seed;
  rom_word_t rom_model [rom_addr_t];
  rom_addr_t rom_addrs [$];

  always #5 clk_sys_117_964 = ~clk_sys_117_964;

  tama_shell #(
    .button_repeat_cycles (repeat_cycles),
    .ui_hold_cycles       (ui_hold),
    .base_div_count       (base_div),
    .suppress_ticks       (suppress),
    .reset_hold_cycles    (reset_hold)
  ) u_tama_shell (.*);

  ////////////////////////////////////////////////////////////
  // helpers

  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("TESTS FAILED");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got === exp) else
      stop_on_error($sformatf("ERROR %s got 0x%0h expected 0x%0h", name, got, exp));
  endtask

  task automatic bridge_write(input bridge_addr_t addr, input bridge_word_t data);
    @(negedge clk_sys_117_964);
    bridge_addr    = addr;
    bridge_wr      = 1'b1;
    bridge_wr_data = data;
    @(negedge clk_sys_117_964);
    // idle on the speed register so read data follows turbo_speed
    bridge_wr   = 1'b0;
    bridge_addr = addr_turbo_speed;
  endtask

  task automatic check_speed(input int exp);
    @(negedge clk_sys_117_964);
    check_value("turbo_speed", bridge_rd_data, exp);
  endtask

  task automatic wait_clk_en();
    int n;
    n = 0;
    do begin
      @(negedge clk_sys_117_964);
      n++;
    end while (!clk_en && n < wait_limit);
    if (!clk_en) stop_on_error("timeout waiting for a clk_en pulse");
  endtask

  function automatic int reload_for(input int speed);
    case (speed)
      0:       return base_div;
      1:       return base_div / 2;
      2:       return base_div / 4;
      3:       return base_div / 50;
      default: return 1;
    endcase
  endfunction

  // skip the period that straddles the speed change, then measure one
  task automatic measure_period(input int speed);
    int gap;
    int ticks_2x;
    bridge_write(addr_turbo_speed, speed);
    wait_clk_en();
    wait_clk_en();
    gap      = 0;
    ticks_2x = 0;
    do begin
      @(negedge clk_sys_117_964);
      gap++;
      if (clk_2x_en) ticks_2x++;
    end while (!clk_en && gap < wait_limit);
    check_value("clk_en_period", gap, reload_for(speed) + 1);
    check_value("clk_2x_en_count", ticks_2x, 2);
  endtask

  // hold one trigger until the target speed, then time the UI hold
  task automatic hold_trigger(input int key_bit, input int start, input int target);
    int speed;
    int step;
    int gap;
    int n;
    speed = start;
    step  = (target > start) ? 1 : -1;
    gap   = 0;
    n     = 0;
    cont1_key[key_bit] = 1'b1;
    while (speed != target && n < wait_limit) begin
      @(negedge clk_sys_117_964);
      n++;
      gap++;
      if (bridge_rd_data != speed) begin
        // released triggers give an immediate first step
        check_value("step_gap", gap, (speed == start) ? 1 : repeat_cycles + 1);
        check_value("turbo_speed", bridge_rd_data, speed + step);
        check_value("turbo_ui_active", turbo_ui_active, 1);
        speed = speed + step;
        gap   = 0;
      end
    end
    cont1_key[key_bit] = 1'b0;
    if (speed != target) stop_on_error("timeout stepping the speed with a trigger");
    n = 0;
    while (turbo_ui_active && n < wait_limit) begin
      @(negedge clk_sys_117_964);
      n++;
    end
    check_value("ui_hold_gap", n, ui_hold + 1);
  endtask

  // one buzzer cycle, turbo_cancel a cycle later, speed zero the next
  task automatic buzz_once(input int speed, input logic cancels);
    @(negedge clk_sys_117_964);
    buzzer = 1'b1;
    @(negedge clk_sys_117_964);
    check_value("turbo_speed", bridge_rd_data, speed);
    buzzer = 1'b0;
    check_speed(cancels ? 0 : speed);
  endtask

  function automatic rom_word_t byte_swap(input rom_word_t w);
    return {w[7:0], w[15:8]};
  endfunction

  ////////////////////////////////////////////////////////////
  // always-on checks

  a_en_pair: assert property (@(posedge clk_sys_117_964) disable iff (ss_begin_reset)
    clk_en |-> clk_2x_en)
    else stop_on_error("clk_en pulsed without clk_2x_en");

  initial begin
    #500us;
    stop_on_error("simulation watchdog expired");
  end

  ////////////////////////////////////////////////////////////
  // stimulus

  initial begin
    rom_word_t d;
    rom_addr_t a;
    int        n;
    ss_begin_reset = 1'b1;
    bridge_addr    = addr_turbo_speed;
    bridge_wr      = 1'b0;
    bridge_wr_data = '0;
    cont1_key      = '0;
    buzzer         = 1'b0;
    rom_wr         = 1'b0;
    rom_wr_addr    = '0;
    rom_wr_data    = '0;
    rom_addr       = '0;
    seed           = 4;
    repeat (5) @(negedge clk_sys_117_964);
    check_value("cpu_reset", cpu_reset, 1);
    ss_begin_reset = 1'b0;
    @(negedge clk_sys_117_964);
    check_value("cpu_reset", cpu_reset, 0);
    check_value("clk_en", clk_en, 0);
    check_value("clk_2x_en", clk_2x_en, 0);
    check_value("turbo_ui_active", turbo_ui_active, 0);
    check_value("turbo_speed", bridge_rd_data, 0);

    // bridge speed writes, saturated above 4
    for (int v = 0; v < 8; v++) begin
      bridge_write(addr_turbo_speed, v);
      check_speed((v > 4) ? 4 : v);
    end
    // other addresses read zero
    for (int i = 0; i < 5; i++) begin
      @(negedge clk_sys_117_964);
      bridge_addr = (i == 4) ? 32'h200 : (i == 0) ? addr_reset_cpu :
                    (i == 1) ? addr_disable_sound : (i == 2) ? addr_cancel_turbo :
                    addr_suppress_turbo;
      @(negedge clk_sys_117_964);
      check_value("bridge_rd_data", bridge_rd_data, 0);
      bridge_addr = addr_turbo_speed;
    end

    for (int s = 0; s < 5; s++) measure_period(s);

    // shoulder buttons up to full speed and back down
    bridge_write(addr_turbo_speed, 0);
    hold_trigger(key_trig_r1, 0, 4);
    hold_trigger(key_trig_l1, 4, 0);

    // a short release clears the repeat delay
    @(negedge clk_sys_117_964);
    cont1_key[key_trig_r1] = 1'b1;
    @(negedge clk_sys_117_964);
    cont1_key[key_trig_r1] = 1'b0;
    check_value("turbo_speed", bridge_rd_data, 1);
    @(negedge clk_sys_117_964);
    cont1_key[key_trig_r1] = 1'b1;
    @(negedge clk_sys_117_964);
    cont1_key[key_trig_r1] = 1'b0;
    check_value("turbo_speed", bridge_rd_data, 2);

    // face keys reach the CPU inverted
    for (int k = 0; k < 8; k++) begin
      @(negedge clk_sys_117_964);
      cont1_key[key_face_a] = k[0];
      cont1_key[key_face_b] = k[1];
      cont1_key[key_face_y] = k[2];
      @(posedge clk_sys_117_964);
      check_value("cpu_input_k0", cpu_input_k0, 4'(7 - k));
    end
    @(negedge clk_sys_117_964);
    cont1_key = '0;

    // buzzer cancels turbo, but not inside the suppress window
    bridge_write(addr_cancel_turbo, 1);
    bridge_write(addr_turbo_speed, 3);
    buzz_once(3, 1'b1);
    bridge_write(addr_suppress_turbo, 1);
    bridge_write(addr_turbo_speed, 2);
    buzzer = 1'b1;
    // still inside the window after two of its three ticks
    repeat (suppress - 1) wait_clk_en();
    repeat (4) check_speed(2);
    buzzer = 1'b0;
    repeat (suppress + 1) wait_clk_en();
    buzz_once(2, 1'b1);
    bridge_write(addr_cancel_turbo, 0);
    bridge_write(addr_suppress_turbo, 0);

    // audio only with sound on and speed below 2
    for (int ds = 0; ds < 2; ds++) begin
      bridge_write(addr_disable_sound, ds);
      for (int s = 0; s < 5; s++) begin
        bridge_write(addr_turbo_speed, s);
        for (int bz = 0; bz < 2; bz++) begin
          buzzer = bz[0];
          @(negedge clk_sys_117_964);
          check_value("audio_sample", audio_sample,
                      (ds == 0 && s < 2 && bz == 1) ? 15'h1fff : 15'h0);
        end
      end
    end
    buzzer = 1'b0;
    bridge_write(addr_disable_sound, 0);

    // random ROM words, read back swapped one cycle after the address
    repeat (32) begin
      a = rom_addr_t'($random(seed));
      d = rom_word_t'($random(seed));
      @(negedge clk_sys_117_964);
      rom_wr      = 1'b1;
      rom_wr_addr = {7'b0, a, 1'b0};
      rom_wr_data = d;
      rom_model[a] = d;
      rom_addrs.push_back(a);
    end
    @(negedge clk_sys_117_964);
    rom_wr = 1'b0;
    foreach (rom_addrs[i]) begin
      rom_addr = rom_addrs[i];
      @(negedge clk_sys_117_964);
      d = byte_swap(rom_model[rom_addrs[i]]);
      check_value("rom_data", rom_data, d[11:0]);
    end

    // CPU reset hold from a bridge write
    check_value("cpu_reset", cpu_reset, 0);
    bridge_write(addr_reset_cpu, 0);
    n = 0;
    while (cpu_reset && n < wait_limit) begin
      n++;
      @(negedge clk_sys_117_964);
    end
    check_value("cpu_reset_cycles", n, reset_hold);

    $display("TESTS PASSED");
    $finish;
  end

endmodule
